// ==== build.f ====
hdl/x11_pkg.sv
hdl/x11_bus_decoder.sv
hdl/unit_activation.sv
hdl/sha_word_fifo.sv
hdl/x11_readback.sv
hdl/x11_regs_top.sv
verification/x11_regs_assertions.sv
verification/x11_regs_tb.sv

// ==== Bender.yml ====
package:
  name: x11_regs

sources:
  - files:
      - hdl/x11_pkg.sv
      - hdl/x11_bus_decoder.sv
      - hdl/unit_activation.sv
      - hdl/sha_word_fifo.sv
      - hdl/x11_readback.sv
      - hdl/x11_regs_top.sv
  - target: test
    files:
      - verification/x11_regs_assertions.sv
      - verification/x11_regs_tb.sv

// ==== verification/x11_regs_tb.sv ====
`default_nettype none

module x11_regs_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import x11_pkg::*;

  localparam int          ACT_DELAY      = 4;
  localparam int          FIFO_DEPTH     = 8;
  localparam int          N_STEPS        = 22;
  localparam int          TIMEOUT_CYCLES = 20 * N_STEPS + 500;  // table plus stream tests
  localparam logic [31:0] SEED           = 32'd22509;

  typedef enum logic [1:0] {
    OP_RD,    // compare rdata
    OP_WR,
    OP_IDLE,  // data column is the cycle count
    OP_ACT    // bit 0 of exp against x11_activated_o
  } op_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;
  } bus_step_t;

  // --------------------------------------------------------------------------
  // register table with reset values then enable and sha reset sequence

  bus_step_t steps [N_STEPS] = '{
    '{OP_ACT,  20'h0,          32'h0,  32'h0},           // nothing released
    '{OP_RD,   REG_CTRL,       32'h0,  32'h0},
    '{OP_RD,   REG_SHA_CTRL,   32'h0,  32'h0},
    '{OP_RD,   REG_KEK_CTRL,   32'h0,  32'h0},
    '{OP_RD,   REG_VERSION,    32'h0,  VERSION_DATE},
    '{OP_RD,   20'h0_0FF0,     32'h0,  32'h0},           // unmapped
    '{OP_RD,   REG_STATUS,     32'h0,  32'h0},
    '{OP_RD,   REG_SHA_STATUS, 32'h0,  32'h10},          // fifo empty
    '{OP_WR,   REG_CTRL,       32'h1,  32'h0},
    '{OP_WR,   REG_SHA_CTRL,   32'h1,  32'h0},
    '{OP_WR,   REG_KEK_CTRL,   32'h1,  32'h0},
    '{OP_IDLE, 20'h0,          32'd10, 32'h0},           // > ACT_DELAY+2
    '{OP_RD,   REG_STATUS,     32'h0,  32'h111},
    '{OP_ACT,  20'h0,          32'h0,  32'h1},
    '{OP_RD,   REG_CTRL,       32'h0,  32'h1},
    '{OP_WR,   REG_SHA_CTRL,   32'h3,  32'h0},           // enable plus reset
    '{OP_RD,   REG_SHA_CTRL,   32'h0,  32'h3},           // reset bit still up
    '{OP_RD,   REG_STATUS,     32'h0,  32'h101},         // sha dropped
    '{OP_RD,   REG_SHA_CTRL,   32'h0,  32'h1},           // self cleared
    '{OP_IDLE, 20'h0,          32'd10, 32'h0},
    '{OP_RD,   REG_STATUS,     32'h0,  32'h111},         // sha back
    '{OP_RD,   REG_SHA_STATUS, 32'h0,  32'h10}
  };

  logic        clk_125mhz;
  logic        rstn_125mhz;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  logic        x11_activated;
  sha_word_t   sha_word;
  logic        sha_valid;
  logic        sha_ready;
  logic        sha_hash_valid;
  hash_t       sha_hash;
  logic [31:0] rng_state = SEED;
  int unsigned cycle_cnt = 0;
  sha_word_t   exp_words [$];
  sha_word_t   got_words [$];  // words taken by the engine

  x11_regs_top #(
    .ACT_DELAY  (ACT_DELAY),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .clk_125mhz       (clk_125mhz),
    .rstn_125mhz      (rstn_125mhz),
    .sys_req_i        (sys_req),
    .sys_rsp_o        (sys_rsp),
    .x11_activated_o  (x11_activated),
    .sha_word_o       (sha_word),
    .sha_valid_o      (sha_valid),
    .sha_ready_i      (sha_ready),
    .sha_hash_valid_i (sha_hash_valid),
    .sha_hash_i       (sha_hash)
  );

  initial begin
    clk_125mhz = 1'b0;
    forever #4 clk_125mhz = ~clk_125mhz;  // 8 ns
  end

  // watchdog and bound checker monitor
  always @(posedge clk_125mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
      abort_run("timeout");
    end else if (dut_i.u_assertions.fail_cnt != 0) begin
      abort_run("a bound assertion failed");
    end
  end

  // --------------------------------------------------------------------------
  // helpers

  task automatic abort_run(input string why);
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_rsp(input string name, input sys_rsp_t exp, input sys_rsp_t got,
                           input bit with_data);
    if (got.ack !== exp.ack || got.err !== exp.err ||
        (with_data && got.rdata !== exp.rdata)) begin
      $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
      abort_run("bus response mismatch");
    end
  endtask

  task automatic check_word(input string name, input sha_word_t exp, input sha_word_t got);
    if (got !== exp) begin
      $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
      abort_run("pushed word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERROR %s: expected 0x%h, got 0x%h", name, exp, got);
      abort_run("flag mismatch");
    end
  endtask

  // inputs for the coming edge already set and outputs still from the last one
  task automatic next_cycle();
    if (sha_valid && sha_ready) begin
      got_words.push_back(sha_word);
    end
    @(posedge clk_125mhz);
    @(negedge clk_125mhz);
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
      check_bit("sys_rsp_o.ack", 1'b0, sys_rsp.ack);  // idle bus gives no ack
    end
  endtask

  task automatic bus_access(input op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
    sys_rsp_t exp_rsp;
    exp_rsp       = '{rdata: exp, ack: 1'b1, err: 1'b0};
    sys_req.addr  = addr;
    sys_req.wdata = data;
    sys_req.wen   = (op == OP_WR);
    sys_req.ren   = (op == OP_RD);
    next_cycle();
    check_rsp($sformatf("sys_rsp_o @0x%05h", addr), exp_rsp, sys_rsp, op == OP_RD);
    sys_req = '0;
  endtask

  // n word pairs of which only the first keep reach the output
  task automatic push_random_words(input int n, input int keep);
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    for (int i = 0; i < n; i++) begin
      lo = next_rand();
      hi = next_rand();
      bus_access(OP_WR, REG_SHA_PUSH, lo, 32'h0);
      bus_access(OP_WR, REG_SHA_PUSH, hi, 32'h0);
      if (i < keep) begin
        exp_words.push_back({hi, lo});  // first write is the low half
      end
    end
  endtask

  task automatic wait_for_words(input int n);
    while (got_words.size() < n) begin
      next_cycle();
    end
  endtask

  task automatic compare_words();
    if (got_words.size() != exp_words.size()) begin
      $display("engine took %0d words where %0d were expected",
               got_words.size(), exp_words.size());
      abort_run("wrong number of words drained");
    end else begin
      for (int i = 0; i < exp_words.size(); i++) begin
        check_word($sformatf("sha_word_o[%0d]", i), exp_words[i], got_words[i]);
      end
      exp_words.delete();
      got_words.delete();
    end
  endtask

  task automatic run_step(input bus_step_t s);
    case (s.op)
      OP_RD, OP_WR: bus_access(s.op, s.addr, s.data, s.exp);
      OP_IDLE:      wait_cycles(s.data);
      default:      check_bit("x11_activated_o", s.exp[0], x11_activated);
    endcase
  endtask

  // --------------------------------------------------------------------------
  // sequence

  initial begin
    hash_t             hash_val;
    logic [ADDR_W-1:0] addr;
    rstn_125mhz    = 1'b0;
    sys_req        = '0;
    sha_ready      = 1'b0;
    sha_hash_valid = 1'b0;
    sha_hash       = '0;
    repeat (8) @(posedge clk_125mhz);
    @(negedge clk_125mhz);
    rstn_125mhz = 1'b1;

    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end

    // pairs straight through to the engine
    sha_ready = 1'b1;
    push_random_words(4, 4);
    wait_for_words(4);
    compare_words();
    check_bit("sha_valid_o", 1'b0, sha_valid);

    // engine stalled so pushes past depth are lost
    sha_ready = 1'b0;
    push_random_words(FIFO_DEPTH - 1, FIFO_DEPTH - 1);
    wait_cycles(2);
    bus_access(OP_RD, REG_SHA_STATUS, 32'h0, 32'h20);  // almost full
    push_random_words(3, 1);
    wait_cycles(2);
    bus_access(OP_RD, REG_SHA_STATUS, 32'h0, 32'h40);  // full
    check_bit("sha_valid_o", 1'b1, sha_valid);
    sha_ready = 1'b1;
    wait_for_words(FIFO_DEPTH);
    wait_cycles(4);  // room for any extra word to show up
    compare_words();
    bus_access(OP_RD, REG_SHA_STATUS, 32'h0, 32'h10);

    // hash capture on a one cycle pulse
    for (int k = 0; k < HASH_W / DATA_W; k++) begin
      hash_val[k*DATA_W +: DATA_W] = next_rand();
    end
    sha_hash       = hash_val;
    sha_hash_valid = 1'b1;
    next_cycle();
    sha_hash_valid = 1'b0;
    wait_cycles(1);
    for (int k = 0; k < HASH_W / DATA_W; k++) begin
      addr = REG_SHA_HASH_H0 - ADDR_W'(4 * k);  // H0 holds the top word
      bus_access(OP_RD, addr, 32'h0, hash_val[HASH_W-1-DATA_W*k -: DATA_W]);
    end
    bus_access(OP_RD, REG_SHA_STATUS, 32'h0, 32'h12);

    // sha off wipes result and captured flag
    bus_access(OP_WR, REG_SHA_CTRL, 32'h0, 32'h0);
    wait_cycles(3);
    for (int k = 0; k < HASH_W / DATA_W; k++) begin
      addr = REG_SHA_HASH_H0 - ADDR_W'(4 * k);
      bus_access(OP_RD, addr, 32'h0, 32'h0);
    end
    bus_access(OP_RD, REG_SHA_STATUS, 32'h0, 32'h10);
    check_bit("x11_activated_o", 1'b1, x11_activated);

    if (dut_i.u_assertions.fail_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("bound assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// ==== verification/x11_regs_assertions.sv ====
`default_nettype none

module x11_regs_assertions (
  input wire logic               clk_i,
  input wire logic               rstn_i,
  input wire x11_pkg::sys_req_t  req_i,
  input wire x11_pkg::sys_rsp_t  rsp_i,
  input wire logic               full_i,
  input wire logic               empty_i,
  input wire logic               sha_active_i,  // fifo flushed while low
  input wire logic               valid_i,
  input wire logic               ready_i,
  input wire x11_pkg::sha_word_t word_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;  // assertion failures so far

  // --------------------------------------------------------------------------
  // bus and fifo properties

  ack_follows_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (req_i.wen || req_i.ren) |=> rsp_i.ack)
  else begin
    $error("bus request without ack on the next cycle");
    fail_cnt++;
  end

  full_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(full_i && empty_i))
  else begin
    $error("fifo full and empty at once");
    fail_cnt++;
  end

  // stalled word holds until taken
  stall_stable: assert property (@(posedge clk_i) disable iff (!rstn_i || !sha_active_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(word_i)))
  else begin
    $error("sha_valid_o or sha_word_o changed while stalled");
    fail_cnt++;
  end

endmodule

bind x11_regs_top x11_regs_assertions u_assertions (
  .clk_i        (clk_125mhz),
  .rstn_i       (rstn_125mhz),
  .req_i        (sys_req_i),
  .rsp_i        (sys_rsp_o),
  .full_i       (fifo_full),
  .empty_i      (fifo_empty),
  .sha_active_i (activated[x11_pkg::UNIT_SHA256]),
  .valid_i      (sha_valid_o),
  .ready_i      (sha_ready_i),
  .word_i       (sha_word_o)
);

`default_nettype wire

// ==== hdl/x11_regs_top.sv ====
`default_nettype none

module x11_regs_top #(
  parameter int ACT_DELAY  = 4,  // release delay of every unit
  parameter int FIFO_DEPTH = 8   // pushed words held for the engine
) (
  input  wire logic               clk_125mhz,
  input  wire logic               rstn_125mhz,
  // system bus
  input  wire x11_pkg::sys_req_t  sys_req_i,
  output x11_pkg::sys_rsp_t       sys_rsp_o,
  output logic                    x11_activated_o,
  // to the sha-256 engine
  output x11_pkg::sha_word_t      sha_word_o,
  output logic                    sha_valid_o,
  input  wire logic               sha_ready_i,
  // from the sha-256 engine
  input  wire logic               sha_hash_valid_i,
  input  wire x11_pkg::hash_t     sha_hash_i
);
  import x11_pkg::*;

  unit_ctrl_t [N_UNITS-1:0]       unit_ctrl;
  logic [N_UNITS-1:0][DATA_W-1:0] ctrl_regs;
  logic [N_UNITS-1:0]             activated;
  sha_word_t                      push_word;
  logic                           push_valid;
  logic                           push_ready;
  logic                           fifo_clear;
  logic                           fifo_empty;
  logic                           fifo_afull;
  logic                           fifo_full;

  // --------------------------------------------------------------------------
  // write side

  x11_bus_decoder i_decoder (
    .clk_125mhz   (clk_125mhz),
    .rstn_125mhz  (rstn_125mhz),
    .sys_req_i    (sys_req_i),
    .fifo_ready_i (push_ready),
    .unit_ctrl_o  (unit_ctrl),
    .ctrl_regs_o  (ctrl_regs),
    .push_word_o  (push_word),
    .push_valid_o (push_valid)
  );

  for (genvar u = 0; u < N_UNITS; u++) begin : g_unit
    unit_activation #(
      .ACT_DELAY (ACT_DELAY)
    ) i_act (
      .clk_125mhz  (clk_125mhz),
      .rstn_125mhz (rstn_125mhz),
      .unit_ctrl_i (unit_ctrl[u]),
      .activated_o (activated[u])
    );
  end

  assign x11_activated_o = activated[UNIT_X11];
  assign fifo_clear      = !activated[UNIT_SHA256];  // flushed while sha is down

  // --------------------------------------------------------------------------
  // word fifo towards the engine

  sha_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk_125mhz    (clk_125mhz),
    .rstn_125mhz   (rstn_125mhz),
    .clear_i       (fifo_clear),
    .push_word_i   (push_word),
    .push_valid_i  (push_valid),
    .push_ready_o  (push_ready),
    .out_word_o    (sha_word_o),
    .out_valid_o   (sha_valid_o),
    .out_ready_i   (sha_ready_i),
    .empty_o       (fifo_empty),
    .almost_full_o (fifo_afull),
    .full_o        (fifo_full)
  );

  // --------------------------------------------------------------------------
  // read side

  x11_readback i_readback (
    .clk_125mhz    (clk_125mhz),
    .rstn_125mhz   (rstn_125mhz),
    .sys_req_i     (sys_req_i),
    .ctrl_regs_i   (ctrl_regs),
    .activated_i   (activated),
    .empty_i       (fifo_empty),
    .almost_full_i (fifo_afull),
    .full_i        (fifo_full),
    .hash_valid_i  (sha_hash_valid_i),
    .hash_i        (sha_hash_i),
    .sys_rsp_o     (sys_rsp_o)
  );

endmodule

`default_nettype wire

// ==== hdl/x11_readback.sv ====
`default_nettype none

module x11_readback (
  input  wire logic                                             clk_125mhz,
  input  wire logic                                             rstn_125mhz,
  input  wire x11_pkg::sys_req_t                                sys_req_i,
  input  wire logic [x11_pkg::N_UNITS-1:0][x11_pkg::DATA_W-1:0] ctrl_regs_i,
  input  wire logic [x11_pkg::N_UNITS-1:0]                      activated_i,
  input  wire logic                                             empty_i,
  input  wire logic                                             almost_full_i,
  input  wire logic                                             full_i,
  input  wire logic                                             hash_valid_i,
  input  wire x11_pkg::hash_t                                   hash_i,
  output x11_pkg::sys_rsp_t                                     sys_rsp_o
);
  import x11_pkg::*;

  localparam int N_HWORDS = HASH_W / DATA_W;  // eight result words

  logic [N_HWORDS-1:0][DATA_W-1:0] hash_q;  // [7] is H0 down to [0] is H7
  logic                            hash_valid_q;  // for edge detect
  logic                            captured_q;
  logic                            capture;
  logic                            sha_active;
  logic [DATA_W-1:0]               status_word;
  logic [DATA_W-1:0]               sha_status_word;
  logic [DATA_W-1:0]               rdata_d;
  logic [DATA_W-1:0]               rdata_q;
  logic                            ack_q;

  assign sha_active = activated_i[UNIT_SHA256];
  assign capture    = hash_valid_i && !hash_valid_q;  // rising edge only

  // --------------------------------------------------------------------------
  // hash capture

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      hash_valid_q <= 1'b0;
      captured_q   <= 1'b0;
    end else begin
      hash_valid_q <= hash_valid_i;
      if (!sha_active) begin
        captured_q <= 1'b0;
      end else if (capture) begin
        captured_q <= 1'b1;
      end
    end
  end

  // zeroed while sha is down
  always_ff @(posedge clk_125mhz) begin
    if (!sha_active) begin
      hash_q <= '0;
    end else if (capture) begin
      hash_q <= hash_i;  // msw lands in H0
    end
  end

  // --------------------------------------------------------------------------
  // status words

  always_comb begin
    status_word = '0;
    for (int u = 0; u < N_UNITS; u++) begin
      status_word[u*STATUS_ACT_STRIDE] = activated_i[u];
    end
  end

  assign sha_status_word = {25'b0, full_i, almost_full_i, empty_i,
                            2'b0, captured_q, 1'b0};

  // --------------------------------------------------------------------------
  // read mux

  always_comb begin
    case (sys_req_i.addr)
      REG_CTRL:        rdata_d = ctrl_regs_i[UNIT_X11];
      REG_STATUS:      rdata_d = status_word;
      REG_VERSION:     rdata_d = VERSION_DATE;
      REG_SHA_CTRL:    rdata_d = ctrl_regs_i[UNIT_SHA256];
      REG_SHA_STATUS:  rdata_d = sha_status_word;
      REG_SHA_HASH_H7: rdata_d = hash_q[0];
      REG_SHA_HASH_H6: rdata_d = hash_q[1];
      REG_SHA_HASH_H5: rdata_d = hash_q[2];
      REG_SHA_HASH_H4: rdata_d = hash_q[3];
      REG_SHA_HASH_H3: rdata_d = hash_q[4];
      REG_SHA_HASH_H2: rdata_d = hash_q[5];
      REG_SHA_HASH_H1: rdata_d = hash_q[6];
      REG_SHA_HASH_H0: rdata_d = hash_q[7];
      REG_KEK_CTRL:    rdata_d = ctrl_regs_i[UNIT_KEK512];
      default:         rdata_d = '0;  // unmapped and push port
    endcase
  end

  // one cycle response with data in the ack cycle
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q   <= sys_req_i.wen || sys_req_i.ren;
      rdata_q <= sys_req_i.ren ? rdata_d : '0;
    end
  end

  assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== hdl/sha_word_fifo.sv ====
`default_nettype none

module sha_word_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire logic               clk_125mhz,
  input  wire logic               rstn_125mhz,
  input  wire logic               clear_i,       // sync flush
  input  wire x11_pkg::sha_word_t push_word_i,
  input  wire logic               push_valid_i,
  output logic                    push_ready_o,
  output x11_pkg::sha_word_t      out_word_o,
  output logic                    out_valid_o,
  input  wire logic               out_ready_i,
  output logic                    empty_o,
  output logic                    almost_full_o,  // one slot left
  output logic                    full_o
);
  import x11_pkg::*;

  localparam int               PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int               LVL_W    = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(FIFO_DEPTH);
  localparam logic [LVL_W-1:0] LVL_AFUL = LVL_W'(FIFO_DEPTH - 1);

  sha_word_t        mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0] level_q;  // words held
  logic             do_push;
  logic             do_pop;

  // --------------------------------------------------------------------------
  // flags and handshake

  assign full_o        = (level_q == LVL_FULL);
  assign almost_full_o = (level_q == LVL_AFUL);
  assign empty_o       = (level_q == '0);

  assign push_ready_o = !full_o;
  assign out_valid_o  = !empty_o;  // held until popped
  assign out_word_o   = mem_q[rd_ptr_q];

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = out_valid_o && out_ready_i;

  // --------------------------------------------------------------------------
  // pointers and level

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: ;  // none, or push and pop together
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_125mhz) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/unit_activation.sv ====
`default_nettype none

module unit_activation #(
  parameter int ACT_DELAY = 4  // cycles of steady enable before release
) (
  input  wire logic                clk_125mhz,
  input  wire logic                rstn_125mhz,
  input  wire x11_pkg::unit_ctrl_t unit_ctrl_i,
  output logic                     activated_o
);

  localparam int               CNT_W    = (ACT_DELAY > 1) ? $clog2(ACT_DELAY) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ACT_DELAY - 1);

  logic [CNT_W-1:0] cnt_q;     // cycles of steady enable so far
  logic             hold_off;  // disabled or reset requested

  assign hold_off = !unit_ctrl_i.enable || unit_ctrl_i.reset_pulse;

  // --------------------------------------------------------------------------
  // release sequencer
  //
  // counter restarts on every disable or reset pulse and the unit
  // is dropped on the same edge, release follows ACT_DELAY edges
  // of clean enable

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      cnt_q       <= '0;
      activated_o <= 1'b0;
    end else if (hold_off) begin
      cnt_q       <= '0;
      activated_o <= 1'b0;  // drop at once
    end else if (!activated_o) begin
      if (cnt_q == CNT_LAST) begin
        activated_o <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/x11_bus_decoder.sv ====
`default_nettype none

module x11_bus_decoder (
  input  wire logic                                          clk_125mhz,
  input  wire logic                                          rstn_125mhz,
  input  wire x11_pkg::sys_req_t                             sys_req_i,
  input  wire logic                                          fifo_ready_i,
  output x11_pkg::unit_ctrl_t [x11_pkg::N_UNITS-1:0]         unit_ctrl_o,
  output logic [x11_pkg::N_UNITS-1:0][x11_pkg::DATA_W-1:0]   ctrl_regs_o,
  output x11_pkg::sha_word_t                                 push_word_o,
  output logic                                               push_valid_o
);
  import x11_pkg::*;

  logic [N_UNITS-1:0][DATA_W-1:0] ctrl_q;  // indexed by unit_e
  logic                           hi_half_q;    // next push fills upper half
  logic                           word_pend_q;  // completed word offered once
  sha_word_t                      word_q;
  logic                           push_wr;

  assign push_wr = sys_req_i.wen && (sys_req_i.addr == REG_SHA_PUSH);

  // --------------------------------------------------------------------------
  // control registers and packer state

  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ctrl_q      <= '0;
      hi_half_q   <= 1'b0;
      word_pend_q <= 1'b0;
    end else begin
      word_pend_q <= 1'b0;
      // reset bits live for one cycle only
      for (int u = 0; u < N_UNITS; u++) begin
        ctrl_q[u][CTRL_RESET_BIT] <= 1'b0;
      end

      if (sys_req_i.wen) begin
        case (sys_req_i.addr)
          REG_CTRL:     ctrl_q[UNIT_X11]    <= sys_req_i.wdata;
          REG_KEK_CTRL: ctrl_q[UNIT_KEK512] <= sys_req_i.wdata;
          REG_SHA_CTRL: begin
            ctrl_q[UNIT_SHA256] <= sys_req_i.wdata;
            if (sys_req_i.wdata[CTRL_RESET_BIT]) begin
              hi_half_q <= 1'b0;  // restart pairing
            end
          end
          REG_SHA_PUSH: begin
            hi_half_q   <= ~hi_half_q;
            word_pend_q <= hi_half_q;  // second half completes the word
          end
          default: ;  // writes to ro or unmapped offsets ignored
        endcase
      end
    end
  end

  // payload halves
  always_ff @(posedge clk_125mhz) begin
    if (push_wr) begin
      if (hi_half_q) begin
        word_q[WORD_W-1:DATA_W] <= sys_req_i.wdata;
      end else begin
        word_q[DATA_W-1:0] <= sys_req_i.wdata;
      end
    end
  end

  // --------------------------------------------------------------------------
  // outputs

  // global enable gates every unit including its own
  always_comb begin
    for (int u = 0; u < N_UNITS; u++) begin
      unit_ctrl_o[u].enable      = ctrl_q[u][CTRL_ENABLE_BIT]
                                 & ctrl_q[UNIT_X11][CTRL_ENABLE_BIT];
      unit_ctrl_o[u].reset_pulse = ctrl_q[u][CTRL_RESET_BIT];
    end
  end

  assign ctrl_regs_o  = ctrl_q;
  assign push_word_o  = word_q;
  assign push_valid_o = word_pend_q & fifo_ready_i;  // word lost when fifo full

endmodule

`default_nettype wire

// ==== hdl/x11_pkg.sv ====
`default_nettype none

package x11_pkg;

  // --------------------------------------------------------------------------
  // widths and sizes

  localparam int ADDR_W  = 20;   // byte offset inside the block
  localparam int DATA_W  = 32;   // bus data
  localparam int WORD_W  = 64;   // one pushed word, two bus writes
  localparam int HASH_W  = 256;  // sha-256 digest
  localparam int N_UNITS = 3;    // global, sha-256, keccak-512

  // build id, yymmddss layout, date fields left open
  localparam logic [DATA_W-1:0] VERSION_DATE = 32'h0000_0001;

  localparam int STATUS_ACT_STRIDE = 4;  // activated bits at 0, 4, 8

  // bit positions, same in every control register
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_RESET_BIT  = 1;    // self clearing

  // --------------------------------------------------------------------------
  // register map

  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL        = 20'h0_0000,
    REG_STATUS      = 20'h0_0004,
    REG_VERSION     = 20'h0_000C,
    REG_SHA_CTRL    = 20'h0_0100,
    REG_SHA_STATUS  = 20'h0_0104,
    REG_SHA_PUSH    = 20'h0_010C,  // write only, lo half first
    REG_SHA_HASH_H7 = 20'h0_0110,  // least significant word
    REG_SHA_HASH_H6 = 20'h0_0114,
    REG_SHA_HASH_H5 = 20'h0_0118,
    REG_SHA_HASH_H4 = 20'h0_011C,
    REG_SHA_HASH_H3 = 20'h0_0120,
    REG_SHA_HASH_H2 = 20'h0_0124,
    REG_SHA_HASH_H1 = 20'h0_0128,
    REG_SHA_HASH_H0 = 20'h0_012C,  // most significant word
    REG_KEK_CTRL    = 20'h0_0200
  } reg_addr_e;

  typedef enum logic [1:0] {
    UNIT_X11    = 2'd0,
    UNIT_SHA256 = 2'd1,
    UNIT_KEK512 = 2'd2
  } unit_e;

  // --------------------------------------------------------------------------
  // bus and internal bundles

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              err;
  } sys_rsp_t;

  typedef struct packed {
    logic enable;       // own enable and global enable
    logic reset_pulse;  // one cycle
  } unit_ctrl_t;

  typedef logic [WORD_W-1:0] sha_word_t;
  typedef logic [HASH_W-1:0] hash_t;

endpackage

`default_nettype wire
